//--- Bender.yml
package:
  name: pipelined_cpu

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - reg_file.sv
      - fetch_stage.sv
      - hazard_unit.sv
      - decode_stage.sv
      - execute_stage.sv
      - memory_writeback.sv
      - pipelined_cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pipelined_cpu.sv

//--- decode_stage.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              clrn,
  input  logic [`XLEN-1:0]  i_dpc4,
  input  logic [`XLEN-1:0]  i_inst,
  input  logic              i_stall,
  input  fwd_sel_e          i_fwda,
  input  fwd_sel_e          i_fwdb,
  input  logic [`XLEN-1:0]  i_ealu,   // forwarded from execute
  input  logic [`XLEN-1:0]  i_malu,   // forwarded from memory
  input  logic [`XLEN-1:0]  i_mmo,    // load data in memory
  input  logic [`RN_W-1:0]  i_wrn,
  input  logic [`XLEN-1:0]  i_wdi,
  input  logic              i_wwreg,
  output pc_sel_e           o_pc_sel,
  output logic [`XLEN-1:0]  o_bpc,
  output logic [`XLEN-1:0]  o_jpc,
  output logic [`RN_W-1:0]  o_rs,
  output logic [`RN_W-1:0]  o_rt,
  output logic              o_use_rs,
  output logic              o_use_rt,
  output logic              o_ewreg,
  output logic              o_em2reg,
  output logic              o_ewmem,
  output alu_op_e           o_ealuc,
  output logic              o_ealuimm,
  output logic [`XLEN-1:0]  o_ea,
  output logic [`XLEN-1:0]  o_eb,
  output logic [`XLEN-1:0]  o_eimm,
  output logic [`RN_W-1:0]  o_ern
);

  inst_u ir;
  logic [`XLEN-1:0] qa, qb, da, db, dimm;
  logic [`RN_W-1:0] drn;
  alu_op_e daluc;
  logic dwreg, dm2reg, dwmem, daluimm;
  logic sext, regrt, is_beq, is_bne, is_j, rsrtequ;

  function automatic logic [`XLEN-1:0] fwd_pick(input fwd_sel_e sel,
                                                input logic [`XLEN-1:0] q,
                                                input logic [`XLEN-1:0] ealu,
                                                input logic [`XLEN-1:0] malu,
                                                input logic [`XLEN-1:0] mmo);
    case (sel)
      fwd_exe_alu:  return ealu;
      fwd_mem_alu:  return malu;
      fwd_mem_load: return mmo;
      default:      return q;
    endcase
  endfunction

  assign ir = i_inst;

  always_comb begin
    dwreg    = 1'b0; // undecoded words write nothing
    dm2reg   = 1'b0;
    dwmem    = 1'b0;
    daluc    = alu_add;
    daluimm  = 1'b0;
    sext     = 1'b0;
    regrt    = 1'b1; // dest is rt except r-type
    o_use_rs = 1'b0;
    o_use_rt = 1'b0;
    is_beq   = 1'b0;
    is_bne   = 1'b0;
    is_j     = 1'b0;
    case (ir.r.op)
      op_rtype: begin
        regrt = 1'b0;
        case (ir.r.funct)
          fn_sub:  daluc = alu_sub;
          fn_and:  daluc = alu_and;
          fn_or:   daluc = alu_or;
          fn_xor:  daluc = alu_xor;
          default: daluc = alu_add;
        endcase
        dwreg    = ir.r.funct inside {fn_add, fn_sub, fn_and, fn_or, fn_xor};
        o_use_rs = dwreg;
        o_use_rt = dwreg;
      end
      op_addi, op_andi, op_ori: begin
        dwreg    = 1'b1;
        daluimm  = 1'b1;
        sext     = (ir.i.op == op_addi); // logic ops zero extend
        o_use_rs = 1'b1;
        if (ir.i.op == op_andi) daluc = alu_and;
        else if (ir.i.op == op_ori) daluc = alu_or;
      end
      op_lw, op_sw: begin
        daluimm  = 1'b1; // base + offset
        sext     = 1'b1;
        o_use_rs = 1'b1;
        dwreg    = (ir.i.op == op_lw);
        dm2reg   = (ir.i.op == op_lw);
        dwmem    = (ir.i.op == op_sw);
        o_use_rt = (ir.i.op == op_sw); // store data
      end
      op_beq, op_bne: begin
        sext     = 1'b1;
        o_use_rs = 1'b1;
        o_use_rt = 1'b1;
        is_beq   = (ir.i.op == op_beq);
        is_bne   = (ir.i.op == op_bne);
      end
      op_j: is_j = 1'b1;
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk   (clk),
    .clrn  (clrn),
    .i_rna (ir.i.rs),
    .i_rnb (ir.i.rt),
    .i_wn  (i_wrn),
    .i_we  (i_wwreg),
    .i_d   (i_wdi),
    .o_qa  (qa),
    .o_qb  (qb)
  );

  assign da = fwd_pick(i_fwda, qa, i_ealu, i_malu, i_mmo);
  assign db = fwd_pick(i_fwdb, qb, i_ealu, i_malu, i_mmo);
  assign rsrtequ = (da == db); // compare after forwarding

  assign dimm  = {{16{sext & ir.i.imm[15]}}, ir.i.imm};
  assign drn   = regrt ? ir.i.rt : ir.r.rd;
  assign o_bpc = i_dpc4 + {dimm[`XLEN-3:0], 2'b00}; // relative to delay slot
  assign o_jpc = {i_dpc4[`XLEN-1:`XLEN-4], ir.i.rs, ir.i.rt, ir.i.imm, 2'b00};
  assign o_rs  = ir.i.rs;
  assign o_rt  = ir.i.rt;

  always_comb begin
    if (is_j) o_pc_sel = pc_jump;
    else if ((is_beq && rsrtequ) || (is_bne && !rsrtequ)) o_pc_sel = pc_branch;
    else o_pc_sel = pc_seq;
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_ewreg   <= 1'b0;
      o_em2reg  <= 1'b0;
      o_ewmem   <= 1'b0;
      o_ealuc   <= alu_add;
      o_ealuimm <= 1'b0;
      o_ea      <= '0;
      o_eb      <= '0;
      o_eimm    <= '0;
      o_ern     <= '0;
    end else begin
      o_ewreg   <= dwreg & ~i_stall; // bubble while stalled
      o_em2reg  <= dm2reg;
      o_ewmem   <= dwmem & ~i_stall;
      o_ealuc   <= daluc;
      o_ealuimm <= daluimm;
      o_ea      <= da;
      o_eb      <= db;
      o_eimm    <= dimm;
      o_ern     <= drn;
    end
  end

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module execute_stage
  import isa_pkg::*;
(
  input  logic             clk,
  input  logic             clrn,
  input  logic             i_ewreg,
  input  logic             i_em2reg,
  input  logic             i_ewmem,
  input  alu_op_e          i_ealuc,
  input  logic             i_ealuimm,
  input  logic [`XLEN-1:0] i_ea,
  input  logic [`XLEN-1:0] i_eb,
  input  logic [`XLEN-1:0] i_eimm,
  input  logic [`RN_W-1:0] i_ern,
  output logic [`XLEN-1:0] o_ealu,   // also forwarded to decode
  output logic             o_mwreg,
  output logic             o_mm2reg,
  output logic             o_mwmem,
  output logic [`XLEN-1:0] o_malu,
  output logic [`XLEN-1:0] o_mb,
  output logic [`RN_W-1:0] o_mrn
);

  logic [`XLEN-1:0] alub;

  assign alub = i_ealuimm ? i_eimm : i_eb; // immediate or rt

  always_comb begin
    case (i_ealuc)
      alu_sub: o_ealu = i_ea - alub;
      alu_and: o_ealu = i_ea & alub;
      alu_or:  o_ealu = i_ea | alub;
      alu_xor: o_ealu = i_ea ^ alub;
      default: o_ealu = i_ea + alub; // add, lw/sw address
    endcase
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_mwreg  <= 1'b0;
      o_mm2reg <= 1'b0;
      o_mwmem  <= 1'b0;
      o_malu   <= '0;
      o_mb     <= '0;
      o_mrn    <= '0;
    end else begin
      o_mwreg  <= i_ewreg;
      o_mm2reg <= i_em2reg;
      o_mwmem  <= i_ewmem;
      o_malu   <= o_ealu;
      o_mb     <= i_eb; // store data
      o_mrn    <= i_ern;
    end
  end

endmodule

//--- fetch_stage.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module fetch_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              clrn,
  input  logic              i_stall,  // hold pc and if/id
  input  pc_sel_e           i_pc_sel,
  input  logic [`XLEN-1:0]  i_bpc,    // branch target from decode
  input  logic [`XLEN-1:0]  i_jpc,    // jump target from decode
  output logic [`XLEN-1:0]  o_pc,
  output logic [`XLEN-1:0]  o_dpc4,
  output logic [`XLEN-1:0]  o_inst
);

  logic [`XLEN-1:0] rom [`IMEM_WORDS]; // program, read only
  logic [$clog2(`IMEM_WORDS)-1:0] iaddr;
  logic [`XLEN-1:0] pc, pc4, npc;
  logic [`XLEN-1:0] d_pc4; // if/id pc + 4
  inst_u d_inst; // if/id instruction

  initial $readmemh("inst_rom.hex", rom);

  assign iaddr = pc[$clog2(`IMEM_WORDS)+1:2]; // word index
  assign pc4 = pc + `PC_STEP;

  always_comb begin
    case (i_pc_sel)
      pc_branch: npc = i_bpc;
      pc_jump:   npc = i_jpc;
      default:   npc = pc4; // sequential, also delay slot
    endcase
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      pc <= `PC_RESET;
    end else if (!i_stall) begin
      pc <= npc;
    end
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      d_pc4  <= '0;
      d_inst <= '0; // nop into decode
    end else if (!i_stall) begin
      d_pc4  <= pc4;
      d_inst <= rom[iaddr];
    end
  end

  assign o_pc   = pc;
  assign o_dpc4 = d_pc4;
  assign o_inst = d_inst;

  // targets from decode are always word multiples
  a_pc_aligned: assert property (@(posedge clk) disable iff (!clrn) pc[1:0] == 2'b00)
    else $error("pc %h not word aligned", pc);

endmodule

//--- hazard_unit.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module hazard_unit
  import pipe_pkg::*;
(
  input  logic             i_use_rs,
  input  logic             i_use_rt,
  input  logic [`RN_W-1:0] i_rs,
  input  logic [`RN_W-1:0] i_rt,
  input  logic [`RN_W-1:0] i_ern,
  input  logic             i_ewreg,
  input  logic             i_em2reg,
  input  logic [`RN_W-1:0] i_mrn,
  input  logic             i_mwreg,
  input  logic             i_mm2reg,
  output fwd_sel_e         o_fwda,
  output fwd_sel_e         o_fwdb,
  output logic             o_stall
);

  logic [`RN_W-1:0] src [2]; // rs, rt
  fwd_sel_e sel [2];
  logic e_load; // load sitting in execute

  assign src[0] = i_rs;
  assign src[1] = i_rt;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      sel[k] = fwd_regfile;
      if (i_ewreg && !i_em2reg && i_ern != '0 && i_ern == src[k]) begin
        sel[k] = fwd_exe_alu; // nearest producer wins
      end else if (i_mwreg && i_mrn != '0 && i_mrn == src[k]) begin
        sel[k] = i_mm2reg ? fwd_mem_load : fwd_mem_alu;
      end
    end
  end

  assign o_fwda = sel[0];
  assign o_fwdb = sel[1];

  assign e_load  = i_ewreg & i_em2reg & (i_ern != '0);
  assign o_stall = e_load & ((i_use_rs & (i_ern == i_rs)) | (i_use_rt & (i_ern == i_rt)));

endmodule

//--- inst_rom.hex
// one 32-bit instruction word per line, starting at pc 00
// word index = pc / 4
20010005 // 00 addi r1,r0,5
20020003 // 04 addi r2,r0,3
00221820 // 08 add r3,r1,r2
00612022 // 0c sub r4,r3,r1
ac030004 // 10 sw r3,4(r0)
8c050004 // 14 lw r5,4(r0)
00a13024 // 18 and r6,r5,r1
00a23825 // 1c or r7,r5,r2
00e14026 // 20 xor r8,r7,r1
340900f0 // 24 ori r9,r0,0xf0
312a0030 // 28 andi r10,r9,0x30
15400002 // 2c bne r10,r0 to 38
200b0001 // 30 addi r11,r0,1
200c0007 // 34 addi r12,r0,7
10220002 // 38 beq r1,r2 to 44
200dffff // 3c addi r13,r0,-1
08000010 // 40 j 40
00000000 // 44 nop

//--- isa_pkg.sv
package isa_pkg;

  typedef enum logic [5:0] {
    op_rtype = 6'h00, // add sub and or xor via funct
    op_j     = 6'h02,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_xor = 6'h26
  } funct_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_e;

  typedef struct packed {
    opcode_e    op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt; // unused, no shifts
    funct_e     funct;
  } r_fmt_s;

  typedef struct packed {
    opcode_e     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm; // rs, rt, imm also form the j target
  } i_fmt_s;

  // one instruction word, two decodings
  typedef union packed {
    r_fmt_s r;
    i_fmt_s i;
  } inst_u;

endpackage

//--- memory_writeback.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module memory_writeback (
  input  logic             clk,
  input  logic             clrn,
  input  logic             i_mwreg,
  input  logic             i_mm2reg,
  input  logic             i_mwmem,
  input  logic [`XLEN-1:0] i_malu,   // address or alu result
  input  logic [`XLEN-1:0] i_mb,     // store data
  input  logic [`RN_W-1:0] i_mrn,
  output logic [`XLEN-1:0] o_mmo,    // load data, forwarded too
  output logic             o_wwreg,
  output logic [`RN_W-1:0] o_wrn,
  output logic [`XLEN-1:0] o_wdi
);

  logic [`XLEN-1:0] ram [`DMEM_WORDS];
  logic [$clog2(`DMEM_WORDS)-1:0] waddr; // word index, bits 6:2
  logic [`XLEN-1:0] wmo, walu;
  logic wm2reg;

  initial begin
    for (int k = 0; k < `DMEM_WORDS; k++) begin
      ram[k] = '0; // data starts cleared
    end
  end

  assign waddr = i_malu[$clog2(`DMEM_WORDS)+1:2];
  assign o_mmo = ram[waddr]; // async read

  always @(posedge clk) begin
    if (i_mwmem) ram[waddr] <= i_mb;
  end

  always_ff @(posedge clk or negedge clrn) begin
    if (!clrn) begin
      o_wwreg <= 1'b0;
      wm2reg  <= 1'b0;
      wmo     <= '0;
      walu    <= '0;
      o_wrn   <= '0;
    end else begin
      o_wwreg <= i_mwreg;
      wm2reg  <= i_mm2reg;
      wmo     <= o_mmo;
      walu    <= i_malu;
      o_wrn   <= i_mrn;
    end
  end

  assign o_wdi = wm2reg ? wmo : walu; // load or alu result

  a_store_in_range: assert property (@(posedge clk) disable iff (!clrn)
    i_mwmem |-> (i_malu >> 2) < `DMEM_WORDS)
    else $error("store address %h beyond data ram", i_malu);

endmodule

//--- mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and address width
`define XLEN 32

`define RN_W 5 // register number width

// memory depths in 32-bit words
`define IMEM_WORDS 64 // instruction rom
`define DMEM_WORDS 32 // data ram

`define PC_STEP 32'd4 // byte step to next instruction
`define PC_RESET 32'd0 // first fetch address

`endif

//--- pipe_pkg.sv
package pipe_pkg;

  // operand source picked in decode
  typedef enum logic [1:0] {
    fwd_regfile  = 2'b00, // no hazard
    fwd_exe_alu  = 2'b01, // alu result in execute
    fwd_mem_alu  = 2'b10, // alu result in memory
    fwd_mem_load = 2'b11  // load data in memory
  } fwd_sel_e;

  // next pc source chosen by decode
  typedef enum logic [1:0] {
    pc_seq    = 2'b00, // pc + 4
    pc_branch = 2'b01, // taken beq/bne
    pc_jump   = 2'b10  // j
  } pc_sel_e;

endpackage

//--- pipelined_cpu.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module pipelined_cpu
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic             clk,
  input  logic             clrn,
  output logic [`XLEN-1:0] o_pc,
  output logic [`XLEN-1:0] o_wdi,   // writeback data
  output logic [`XLEN-1:0] o_malu,  // alu result in memory stage
  output logic [`XLEN-1:0] o_mb,    // store data
  output logic [`RN_W-1:0] o_wrn,
  output logic             o_wwreg,
  output logic             o_mwmem
);

  pc_sel_e pc_sel;
  fwd_sel_e fwda, fwdb;
  alu_op_e ealuc;
  logic [`XLEN-1:0] bpc, jpc, dpc4, inst;
  logic [`XLEN-1:0] ea, eb, eimm, ealu, mmo;
  logic [`RN_W-1:0] rs, rt, ern, mrn;
  logic stall, use_rs, use_rt;
  logic ewreg, em2reg, ewmem, ealuimm;
  logic mwreg, mm2reg;

  fetch_stage u_fetch (
    .clk(clk), .clrn(clrn), .i_stall(stall), .i_pc_sel(pc_sel),
    .i_bpc(bpc), .i_jpc(jpc), .o_pc(o_pc), .o_dpc4(dpc4), .o_inst(inst)
  );

  decode_stage u_decode (
    .clk(clk), .clrn(clrn), .i_dpc4(dpc4), .i_inst(inst), .i_stall(stall),
    .i_fwda(fwda), .i_fwdb(fwdb), .i_ealu(ealu), .i_malu(o_malu), .i_mmo(mmo),
    .i_wrn(o_wrn), .i_wdi(o_wdi), .i_wwreg(o_wwreg),
    .o_pc_sel(pc_sel), .o_bpc(bpc), .o_jpc(jpc), .o_rs(rs), .o_rt(rt),
    .o_use_rs(use_rs), .o_use_rt(use_rt), .o_ewreg(ewreg), .o_em2reg(em2reg),
    .o_ewmem(ewmem), .o_ealuc(ealuc), .o_ealuimm(ealuimm),
    .o_ea(ea), .o_eb(eb), .o_eimm(eimm), .o_ern(ern)
  );

  hazard_unit u_hazard (
    .i_use_rs(use_rs), .i_use_rt(use_rt), .i_rs(rs), .i_rt(rt),
    .i_ern(ern), .i_ewreg(ewreg), .i_em2reg(em2reg),
    .i_mrn(mrn), .i_mwreg(mwreg), .i_mm2reg(mm2reg),
    .o_fwda(fwda), .o_fwdb(fwdb), .o_stall(stall)
  );

  execute_stage u_execute (
    .clk(clk), .clrn(clrn), .i_ewreg(ewreg), .i_em2reg(em2reg), .i_ewmem(ewmem),
    .i_ealuc(ealuc), .i_ealuimm(ealuimm), .i_ea(ea), .i_eb(eb), .i_eimm(eimm),
    .i_ern(ern), .o_ealu(ealu), .o_mwreg(mwreg), .o_mm2reg(mm2reg),
    .o_mwmem(o_mwmem), .o_malu(o_malu), .o_mb(o_mb), .o_mrn(mrn)
  );

  memory_writeback u_memwb (
    .clk(clk), .clrn(clrn), .i_mwreg(mwreg), .i_mm2reg(mm2reg), .i_mwmem(o_mwmem),
    .i_malu(o_malu), .i_mb(o_mb), .i_mrn(mrn),
    .o_mmo(mmo), .o_wwreg(o_wwreg), .o_wrn(o_wrn), .o_wdi(o_wdi)
  );

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module reg_file (
  input  logic             clk,
  input  logic             clrn,
  input  logic [`RN_W-1:0] i_rna,
  input  logic [`RN_W-1:0] i_rnb,
  input  logic [`RN_W-1:0] i_wn,
  input  logic             i_we,
  input  logic [`XLEN-1:0] i_d,
  output logic [`XLEN-1:0] o_qa,
  output logic [`XLEN-1:0] o_qb
);

  logic [`XLEN-1:0] regs [1:(1 << `RN_W) - 1]; // r0 has no storage

  assign o_qa = (i_rna == '0) ? '0 : regs[i_rna];
  assign o_qb = (i_rnb == '0) ? '0 : regs[i_rnb];

  // falling edge, so decode sees the value in the same cycle
  always_ff @(negedge clk or negedge clrn) begin
    if (!clrn) begin
      for (int k = 1; k < (1 << `RN_W); k++) begin
        regs[k] <= '0;
      end
    end else if (i_we && i_wn != '0) begin
      regs[i_wn] <= i_d;
    end
  end

  a_no_r0_write: assert property (@(negedge clk) disable iff (!clrn) i_we |-> i_wn != '0)
    else $error("writeback targets r0");

endmodule

//--- tb_pipelined_cpu.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_pipelined_cpu;

  localparam int N_WB = 12;        // writebacks in the program
  localparam int WAIT_LIMIT = 20;  // cycles allowed per writeback
  localparam int IDLE_CYCLES = 50; // quiet window after the trace

  logic clk;
  logic clrn;
  logic [`XLEN-1:0] o_pc, o_wdi, o_malu, o_mb;
  logic [`RN_W-1:0] o_wrn;
  logic o_wwreg, o_mwmem;

  logic [`RN_W-1:0] wb_rn [N_WB]; // expected writeback trace
  logic [`XLEN-1:0] wb_val [N_WB];
  logic [`XLEN-1:0] st_addr [1];  // expected store
  logic [`XLEN-1:0] st_data [1];

  logic [`XLEN-1:0] seen_val [32]; // last value written per register
  bit seen_wr [32];
  int wb_cycle [N_WB];             // cycle of each writeback
  logic [`XLEN-1:0] seen_st_addr [$];
  logic [`XLEN-1:0] seen_st_data [$];
  bit store_after_r5;
  bit timed_out;
  int cycle;
  int checks, errors, test_errs;

  pipelined_cpu UUT (
    .clk(clk), .clrn(clrn), .o_pc(o_pc), .o_wdi(o_wdi), .o_malu(o_malu),
    .o_mb(o_mb), .o_wrn(o_wrn), .o_wwreg(o_wwreg), .o_mwmem(o_mwmem)
  );

  always #4 clk = ~clk; // 8 ns period

  task automatic check_value(input string name, input logic [`XLEN-1:0] exp,
                             input logic [`XLEN-1:0] act);
    checks++;
    assert (act === exp)
      else begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        errors++;
        test_errs++;
      end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s (%0d errors)", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    test_errs = 0;
  endtask

  task automatic set_expect(input int idx, input int rn, input logic [`XLEN-1:0] val);
    wb_rn[idx]  = rn[`RN_W-1:0];
    wb_val[idx] = val;
  endtask

  // expected results follow the instruction rules of the test program
  task automatic build_tables();
    logic [`XLEN-1:0] r1, r2, r3, r5, r7, r9;
    r1 = 32'd5;
    r2 = 32'd3;
    r3 = r1 + r2;
    r5 = r3;      // stored, then loaded back
    r7 = r5 | r2;
    r9 = 32'h0 | 32'h0000_00f0; // ori zero extends
    set_expect(0, 1, r1);
    set_expect(1, 2, r2);
    set_expect(2, 3, r3);
    set_expect(3, 4, r3 - r1);
    set_expect(4, 5, r5);
    set_expect(5, 6, r5 & r1);
    set_expect(6, 7, r7);
    set_expect(7, 8, r7 ^ r1);
    set_expect(8, 9, r9);
    set_expect(9, 10, r9 & 32'h0000_0030);
    set_expect(10, 11, 32'd1); // delay slot of bne
    set_expect(11, 13, 32'h0 + {{16{1'b1}}, 16'hffff}); // addi sign extends
    st_addr[0] = 32'h0 + 32'd4;
    st_data[0] = r3;
  endtask

  // steps on falling edges until a writeback shows up, logging stores on the way
  task automatic wait_writeback(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !ok; n++) begin
      @(negedge clk);
      cycle++;
      if (o_mwmem) begin
        seen_st_addr.push_back(o_malu);
        seen_st_data.push_back(o_mb);
        if (seen_wr[5]) store_after_r5 = 1'b1;
      end
      if (o_wwreg) ok = 1'b1;
    end
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    clrn = 1'b0;
    checks = 0;
    errors = 0;
    test_errs = 0;
    cycle = 0;
    timed_out = 1'b0;
    store_after_r5 = 1'b0;
    for (int k = 0; k < 32; k++) begin
      seen_wr[k]  = 1'b0;
      seen_val[k] = '0;
    end
    build_tables();

    repeat (16) begin // reset held 16 cycles
      @(negedge clk);
      check_value("reset_quiet wwreg", 1'b0, o_wwreg);
      check_value("reset_quiet mwmem", 1'b0, o_mwmem);
    end
    @(posedge clk);
    #1 clrn = 1'b1;
    @(negedge clk);
    check_value("reset_quiet pc", `PC_RESET, o_pc); // fetched at next edge
    report_test("reset_quiet");

    for (int i = 0; i < N_WB; i++) begin
      wait_writeback(ok);
      if (!ok) begin
        $display("no writeback within %0d cycles for trace entry %0d", WAIT_LIMIT, i);
        errors++;
        test_errs++;
        timed_out = 1'b1;
        break;
      end
      wb_cycle[i] = cycle;
      check_value($sformatf("writeback_trace[%0d] reg", i), wb_rn[i], o_wrn);
      check_value($sformatf("writeback_trace[%0d] data", i), wb_val[i], o_wdi);
      seen_wr[o_wrn]  = 1'b1;
      seen_val[o_wrn] = o_wdi;
    end
    report_test("writeback_trace");

    if (!timed_out) begin
      // and r6 waits one extra cycle behind lw r5
      check_value("load_use gap lw to and", 2, wb_cycle[5] - wb_cycle[4]);
      check_value("load_use gap and to or", 1, wb_cycle[6] - wb_cycle[5]);
      check_value("load_use r6", wb_val[5], seen_val[6]);
      check_value("load_use r7", wb_val[6], seen_val[7]);
      report_test("load_use");

      check_value("store count", 1, seen_st_addr.size());
      for (int s = 0; s < 1 && s < seen_st_addr.size(); s++) begin
        check_value($sformatf("store[%0d] addr", s), st_addr[s], seen_st_addr[s]);
        check_value($sformatf("store[%0d] data", s), st_data[s], seen_st_data[s]);
      end
      check_value("store before r5", 1'b0, store_after_r5);
      report_test("store");

      check_value("branch r11 written", 1'b1, seen_wr[11]);
      check_value("branch r12 skipped", 1'b0, seen_wr[12]);
      check_value("branch r13 written", 1'b1, seen_wr[13]);
      repeat (IDLE_CYCLES) begin // j loop must stay silent
        @(negedge clk);
        check_value("branch idle wwreg", 1'b0, o_wwreg);
        check_value("branch idle mwmem", 1'b0, o_mwmem);
      end
      report_test("branch");
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
reg_file.sv
fetch_stage.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
memory_writeback.sv
pipelined_cpu.sv
tb_pipelined_cpu.sv
